// File: bench/quantizer_assertions.sv
`timescale 1ns/1ns

module quantizer_assertions import quant_types_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid,
	input coef_block_t out_block
);

	// The valid bit passes through exactly four register stages.
	valid_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, 4))
	else $error("out_valid does not follow in_valid by four cycles");

	// The output register only loads together with out_valid.
	block_held: assert property (@(posedge clk) disable iff (rst)
		!out_valid |-> $stable(out_block))
	else $error("out_block changed while out_valid was low");

	reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
	else $error("out_valid was high during reset");

endmodule

bind quantizer_top quantizer_assertions i_assertions (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.out_block(out_block)
);

// File: bench/quantizer_tb_tasks.svh
	// ************************************************************************
	// Random numbers
	// ************************************************************************

	// Fibonacci LFSR with taps 32, 22, 2 and 1, a maximal length polynomial.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// Steps the generator once per bit and collects the new bits, LSB last.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// ************************************************************************
	// Waits
	// ************************************************************************

	task automatic wait_for_drain(input int limit);
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			abort_run($sformatf("Timed out after %0d cycles with %0d blocks still expected",
				limit, expected_q.size()));
		end
	endtask

	// ************************************************************************
	// Compares
	// ************************************************************************

	task automatic compare_block(input string name, input coef_block_t got,
		input coef_block_t want);
		coef_t got_coef;
		coef_t want_coef;
		for (int i = 0; i < block_size; i++) begin
			got_coef = got[i];
			want_coef = want[i];
			if (got_coef !== want_coef) begin
				$display("Error at %0t ns: %s[%0d] is %0d, expected %0d",
					$time, name, i, got_coef, want_coef);
				error_count++;
			end
		end
	endtask

	task automatic compare_valid(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
			error_count++;
		end
	endtask

// File: bench/quantizer_tb.sv
`timescale 1ns/1ns

module quantizer_tb import quant_types_pkg::*, quant_table_pkg::*; ();

	typedef struct packed {
		coef_block_t block; // Reference result for the block.
		int unsigned sample_cycle; // Clock edge that takes the block in.
	} sent_t;

	localparam int unsigned latency = 4;
	localparam int drain_limit = 40;

	logic clk;
	logic rst;
	logic in_valid;
	coef_block_t in_block;
	logic out_valid;
	coef_block_t out_block;

	logic [31:0] lfsr_state;
	int unsigned cycle_count;
	int error_count;
	int tests_run;
	int tests_failed;
	sent_t expected_q[$];
	coef_block_t last_block; // Last reference result, which out_block must hold.

	`include "quantizer_tb_tasks.svh"

	quantizer_top i_dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_block(in_block),
		.out_valid(out_valid),
		.out_block(out_block)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 32'd1;
	end

	// ************************************************************************
	// Reference model and stimulus helpers
	// ************************************************************************

	// floor((z * floor(4096 / step) + 2048) / 4096) for every position.
	function automatic coef_block_t ref_quantize(input coef_block_t blk,
		input step_table_t steps);
		coef_block_t result;
		coef_t coef;
		int recip;
		int num;
		int quot;
		for (int i = 0; i < block_size; i++) begin
			coef = blk[i];
			recip = (steps[i] == '0) ? 0 : 4096 / int'(steps[i]);
			num = int'(coef) * recip + 2048;
			if (num >= 0) begin
				quot = num / 4096;
			end else begin
				quot = -((-num + 4095) / 4096); // Floor for negative numbers.
			end
			result[i] = coef_t'(quot);
		end
		return result;
	endfunction

	function automatic coef_block_t random_block();
		coef_block_t blk;
		for (int i = 0; i < block_size; i++) begin
			blk[i] = coef_t'(rand_bits(coef_w));
		end
		return blk;
	endfunction

	function automatic coef_block_t uniform_block(input coef_t value);
		coef_block_t blk;
		for (int i = 0; i < block_size; i++) begin
			blk[i] = value;
		end
		return blk;
	endfunction

	// Picks coefficients whose scaled value ends in exactly one half.
	// Odd positions get the negative one, which may reach -1024.
	function automatic coef_block_t tie_block(input step_table_t steps);
		coef_block_t blk;
		int recip;
		int tie;
		for (int i = 0; i < block_size; i++) begin
			recip = (steps[i] == '0) ? 0 : 4096 / int'(steps[i]);
			tie = 0;
			for (int z = 1; z <= 1024 && tie == 0; z++) begin
				if ((z * recip) % 4096 == 2048 && (z < 1024 || i % 2 == 1)) begin
					tie = z;
				end
			end
			blk[i] = (i % 2 == 1) ? coef_t'(-tie) : coef_t'(tie);
		end
		return blk;
	endfunction

	task automatic send_block(input coef_block_t blk);
		sent_t entry;
		@(negedge clk);
		in_valid = 1'b1;
		in_block = blk;
		entry.block = ref_quantize(blk, chroma_steps);
		entry.sample_cycle = cycle_count + 32'd1;
		expected_q.push_back(entry);
	endtask

	task automatic go_idle(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			in_valid = 1'b0;
			in_block = random_block(); // Junk data the DUT must ignore.
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("Test %0d, %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d, %s: failed with %0d errors", tests_run, name,
				error_count - errors_before);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$finish;
	endtask

	// ************************************************************************
	// Output checker
	// ************************************************************************

	always @(negedge clk) begin : compare_outputs
		sent_t head;
		logic due;
		due = 1'b0;
		if (!rst) begin
			if (expected_q.size() != 0) begin
				// The next rising edge samples what out_valid shows now.
				due = (expected_q[0].sample_cycle + latency == cycle_count + 32'd1);
			end
			compare_valid("out_valid", out_valid, due);
			if (due) begin
				head = expected_q.pop_front();
			end
			if (due && out_valid) begin
				compare_block("out_block", out_block, head.block);
				last_block = head.block;
			end else if (!out_valid) begin
				compare_block("out_block", out_block, last_block); // Must hold.
			end
		end
	end

	// ************************************************************************
	// Tests
	// ************************************************************************

	initial begin : stimulus
		int errs;
		int gap;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_block = '0;
		lfsr_state = 32'h1d4d_9799;
		cycle_count = 0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		last_block = '0;

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		errs = error_count;
		@(negedge clk);
		compare_valid("out_valid", out_valid, 1'b0);
		compare_block("out_block", out_block, '0);
		report_test("idle after reset", errs);

		errs = error_count;
		send_block(random_block());
		go_idle(1);
		wait_for_drain(drain_limit);
		report_test("single random block", errs);

		errs = error_count;
		for (int n = 0; n < 16; n++) begin
			send_block(random_block()); // Back to back, four blocks in flight.
		end
		go_idle(1);
		wait_for_drain(drain_limit);
		report_test("sixteen consecutive blocks", errs);

		errs = error_count;
		send_block(uniform_block(coef_t'(1023)));
		send_block(uniform_block(coef_t'(-1024)));
		send_block(tie_block(chroma_steps));
		go_idle(1);
		wait_for_drain(drain_limit);
		report_test("extreme and tie values", errs);

		errs = error_count;
		for (int n = 0; n < 20; n++) begin
			send_block(random_block());
			gap = int'(rand_bits(2));
			if (gap > 0) begin
				go_idle(gap);
			end
		end
		go_idle(1);
		wait_for_drain(drain_limit);
		report_test("random gaps in in_valid", errs);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the quantizer testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=obj_dir/quantizer_sim

verilator --binary --timing --assert -Mdir obj_dir -o quantizer_sim \
	--top-module quantizer_tb -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status."
	exit 1
fi

grep -q -F -- ">>> FAIL" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ]; then
	echo "Simulation reported a failure."
	exit 1
elif [ $grep_status -ne 1 ]; then
	echo "Could not search $log_file."
	exit 1
fi

echo "Simulation finished without failures."
exit 0

// File: sim.f
+incdir+bench
src/quant_types_pkg.sv
src/quant_table_pkg.sv
src/quant_ctrl.sv
src/coef_scaler.sv
src/coef_rounder.sv
src/quantizer_top.sv
bench/quantizer_assertions.sv
bench/quantizer_tb.sv

// File: src/coef_rounder.sv
`timescale 1ns/1ns

module coef_rounder import quant_types_pkg::*, quant_table_pkg::*; (
	input logic clk,
	input logic rst,
	input logic round_en,
	input prod_block_t prod_block,
	output coef_block_t out_block
);

	localparam int int_w = prod_w - frac_w; // Integer part, as wide as coef_t.

	coef_block_t round_d;

	// ************************************************************************
	// Round to nearest, ties toward plus infinity
	// ************************************************************************

	// Adding the first fraction bit to the floor of the product rounds
	// halves upward for both signs, so -2.5 becomes -2 and 2.5 becomes 3.
	for (genvar i = 0; i < block_size; i++) begin : g_round
		logic [int_w-1:0] int_part;
		logic half;

		assign int_part = prod_block[i][prod_w-1:frac_w]; // Floor of the product.
		assign half = prod_block[i][frac_w-1];
		assign round_d[i] = coef_t'(int_part + int_w'(half));
	end

	// ************************************************************************
	// Stage 4, output register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			out_block <= '0;
		end else if (round_en) begin
			out_block <= round_d; // Holds its value between blocks.
		end
	end

endmodule

// File: src/coef_scaler.sv
`timescale 1ns/1ns

module coef_scaler import quant_types_pkg::*, quant_table_pkg::*; #(
	parameter step_table_t steps = chroma_steps
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input coef_block_t in_block,
	input logic scale_en,
	input logic hold_en,
	output prod_block_t prod_block
);

	// Reciprocal with a zero sign bit on top, so the multiply stays signed.
	typedef logic signed [recip_w:0] srecip_t;

	coef_block_t coef_q; // Captured block.
	prod_block_t prod_d; // Products of the captured block.
	prod_block_t prod_q; // Registered products.

	// ************************************************************************
	// Stage 1, capture
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			coef_q <= '0;
		end else if (in_valid) begin
			coef_q <= in_block;
		end
	end

	// ************************************************************************
	// Stage 2, multiply by the reciprocal of each position's step
	// ************************************************************************

	for (genvar i = 0; i < block_size; i++) begin : g_mult
		localparam srecip_t recip = srecip_t'({1'b0, recip_of(steps[i])});

		// The true product always fits in prod_w bits.
		assign prod_d[i] = prod_t'(coef_q[i] * recip);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_q <= '0;
		end else if (scale_en) begin
			prod_q <= prod_d;
		end
	end

	// ************************************************************************
	// Stage 3, hold
	// ************************************************************************

	// An extra register after the multipliers gives retiming room for
	// the 64 parallel multiplies.
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_block <= '0;
		end else if (hold_en) begin
			prod_block <= prod_q;
		end
	end

endmodule

// File: src/quant_ctrl.sv
`timescale 1ns/1ns

module quant_ctrl (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic scale_en,
	output logic hold_en,
	output logic round_en,
	output logic out_valid
);

	// Bit n is in_valid delayed by n + 1 cycles. Each set bit marks a block
	// sitting in the matching stage of the datapath.
	logic [3:0] valid_sr;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[2:0], in_valid};
		end
	end

	assign scale_en = valid_sr[0]; // Capture register holds a new block.
	assign hold_en = valid_sr[1]; // Product register holds a new block.
	assign round_en = valid_sr[2]; // Hold register holds a new block.
	assign out_valid = valid_sr[3]; // Output register holds a new block.

endmodule

// File: src/quant_table_pkg.sv
package quant_table_pkg;
	import quant_types_pkg::*;

	// ************************************************************************
	// Fixed point format of the reciprocals
	// ************************************************************************

	localparam int frac_w = 12; // The reciprocal of step s is 4096 / s.
	localparam int recip_w = frac_w + 1; // A step of 1 gives 4096, one bit wider.

	// ************************************************************************
	// Quantization steps
	// ************************************************************************

	typedef logic [7:0] step_t; // Legal range is 1 to 255.

	typedef step_t [0:block_size-1] step_table_t; // Row-major, like coef_block_t.

	// Standard JPEG chrominance table, one row of the block per line.
	localparam step_table_t chroma_steps = '{
		17, 18, 24, 47, 99, 99, 99, 99,
		18, 21, 26, 66, 99, 99, 99, 99,
		24, 26, 56, 99, 99, 99, 99, 99,
		47, 66, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99
	};

	// ************************************************************************
	// Reciprocal of a step, evaluated at elaboration
	// ************************************************************************

	function automatic logic [recip_w-1:0] recip_of(input step_t step);
		logic [recip_w-1:0] recip;
		if (step == '0) begin
			recip = '0; // A zero step quantizes everything to zero.
		end else begin
			recip = recip_w'((32'd1 << frac_w) / step); // Truncates toward zero.
		end
		return recip;
	endfunction

endpackage

// File: src/quant_types_pkg.sv
package quant_types_pkg;

	// ************************************************************************
	// Block geometry
	// ************************************************************************

	localparam int block_dim = 8; // Rows and columns of a DCT block.
	localparam int block_size = block_dim * block_dim;

	// ************************************************************************
	// Coefficients
	// ************************************************************************

	localparam int coef_w = 11;

	typedef logic signed [coef_w-1:0] coef_t;

	// Element 0 is the DC term at the top left, and the index walks along
	// each row before moving to the next one. Element 0 sits in the upper
	// bits of the flat vector.
	typedef coef_t [0:block_size-1] coef_block_t;

	// ************************************************************************
	// Scaled products
	// ************************************************************************

	// A coefficient times a reciprocal of up to 4096 lands in 23 bits, so
	// -1024 * 4096 still fits.
	localparam int prod_w = 23;

	typedef logic signed [prod_w-1:0] prod_t;

	typedef prod_t [0:block_size-1] prod_block_t; // Same order as coef_block_t.

endpackage

// File: src/quantizer_top.sv
`timescale 1ns/1ns

module quantizer_top import quant_types_pkg::*, quant_table_pkg::*; #(
	parameter step_table_t steps = chroma_steps
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input coef_block_t in_block,
	output logic out_valid,
	output coef_block_t out_block
);

	logic scale_en;
	logic hold_en;
	logic round_en;
	prod_block_t prod_block;

	// ************************************************************************
	// Stage enables
	// ************************************************************************

	quant_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.scale_en(scale_en),
		.hold_en(hold_en),
		.round_en(round_en),
		.out_valid(out_valid)
	);

	// ************************************************************************
	// Datapath
	// ************************************************************************

	coef_scaler #(
		.steps(steps)
	) i_scaler (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_block(in_block),
		.scale_en(scale_en),
		.hold_en(hold_en),
		.prod_block(prod_block)
	);

	coef_rounder i_rounder (
		.clk(clk),
		.rst(rst),
		.round_en(round_en),
		.prod_block(prod_block),
		.out_block(out_block)
	);

endmodule
